// File: tb.f
logic/pixels_pkg.sv
logic/pixels_if.sv
logic/pixel_cfg_decode.sv
logic/pixel_dw_pack.sv
logic/pixel_out_seq.sv
logic/pixels_dw_top.sv
test/pixels_dw_assertions.sv
test/pixels_dw_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := pixels_dw_tb
FILELIST   := tb.f
BUILD_DIR  := obj_dir
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: test/pixels_dw_tb.sv
module pixels_dw_tb import pixels_pkg::*; ();

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_FRAMES   = 6;

  typedef struct packed {
    logic [BITS_KH2-1:0]   kh2;
    logic [BITS_KW2-1:0]   kw2;
    logic [BITS_SH-1:0]    sh_1;
    logic [BITS_WORDS-1:0] words;
    user_t                 flags;
    logic [3:0]            beats;
    s_keep_t               last_keep;
  } frame_row_t;

  // kh2, kw2, sh_1, words, flags, data beats, keep of the final data beat
  localparam frame_row_t FRAMES [NUM_FRAMES] = '{
    '{2'd1, 2'd1, 2'd0, 4'd4, 3'b001, 4'd4, 4'b1111},
    '{2'd3, 2'd3, 2'd1, 4'd3, 3'b110, 4'd5, 4'b0111},
    '{2'd2, 2'd0, 2'd3, 4'd8, 3'b010, 4'd7, 4'b0101},
    '{2'd0, 2'd2, 2'd0, 4'd2, 3'b101, 4'd3, 4'b1000},
    '{2'd3, 2'd1, 2'd3, 4'd5, 3'b001, 4'd2, 4'b1111},
    '{2'd1, 2'd3, 2'd1, 4'd7, 3'b100, 4'd1, 4'b0110}
  };

  logic    i_aclk;
  logic    i_rst_n;
  logic    i_s_valid;
  logic    o_s_ready;
  s_data_t i_s_data;
  s_keep_t i_s_keep;
  logic    i_s_last;
  logic    i_m_ready;
  logic    o_m_valid;
  m_data_t o_m_data;
  shift_t  o_m_shift;
  logic    o_m_ones;
  logic    o_m_last;
  user_t   o_m_user;
  integer  seed = 2697;

  s_data_t in_data_q[$];
  s_keep_t in_keep_q[$];
  logic    in_last_q[$];
  m_data_t exp_data_q[$];
  shift_t  exp_shift_q[$];
  user_t   exp_user_q[$];
  logic    exp_ones_q[$];
  logic    exp_last_q[$];

  pixels_dw_top u_pixels_dw_top (
    .i_aclk    (i_aclk),
    .i_rst_n   (i_rst_n),
    .i_s_valid (i_s_valid),
    .o_s_ready (o_s_ready),
    .i_s_data  (i_s_data),
    .i_s_keep  (i_s_keep),
    .i_s_last  (i_s_last),
    .i_m_ready (i_m_ready),
    .o_m_valid (o_m_valid),
    .o_m_data  (o_m_data),
    .o_m_shift (o_m_shift),
    .o_m_ones  (o_m_ones),
    .o_m_last  (o_m_last),
    .o_m_user  (o_m_user)
  );

  initial begin
    i_aclk = 1'b0;
    forever #(CLK_PERIOD / 2) i_aclk = ~i_aclk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "run stopped after a failure");
  endtask

  task automatic check_data(input string name, input m_data_t exp, input m_data_t act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %h actual %h", $time, name, exp, act);
      fail_run("output beat does not match the model");
    end
  endtask

  task automatic check_shift(input string name, input shift_t exp, input shift_t act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %0d actual %0d", $time, name, exp, act);
      fail_run("output beat does not match the model");
    end
  endtask

  task automatic check_user(input string name, input user_t exp, input user_t act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %b actual %b", $time, name, exp, act);
      fail_run("output beat does not match the model");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %b actual %b", $time, name, exp, act);
      fail_run("output beat does not match the model");
    end
  endtask

  function automatic shift_t model_shift(input int kh2, input int sh_1, input bit closing);
    int k;
    int s;
    int q;
    k = 2 * kh2 + 1;
    s = sh_1 + 1;
    q = k / s;
    if (!closing && q * s != k) begin
      q = q + 1;  // rounds up on every beat except the one that closes a stride group
    end
    return shift_t'(q - 1);
  endfunction

  function automatic int watchdog_cycles();
    int beats;
    beats = RESET_CYCLES;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      beats += 2 + int'(FRAMES[f].beats) + int'(FRAMES[f].kw2);  // header, data, ones
      beats += (int'(FRAMES[f].beats) * S_WORDS + int'(FRAMES[f].words) - 1) /
               int'(FRAMES[f].words);
    end
    return beats * 20;
  endfunction

  // queues the input beats of one frame and the output beats it should produce
  task automatic build_frame(input frame_row_t row);
    word_t   words_q[$];
    s_data_t beat;
    s_keep_t keep;
    m_data_t out;
    int      w;
    int      s;
    int      n_out;
    beat = s_data_t'((S_WORDS * WORD_WIDTH)'({row.words, row.sh_1, row.kw2, row.kh2,
           row.flags[I_IS_LRELU], row.flags[I_IS_MAX], row.flags[I_IS_NOT_MAX]}));
    in_data_q.push_back(beat);
    in_keep_q.push_back('1);
    in_last_q.push_back(1'b0);
    for (int b = 0; b < int'(row.beats); b++) begin
      for (int i = 0; i < S_WORDS; i++) begin
        beat[i] = word_t'($random(seed));
      end
      keep = (b == int'(row.beats) - 1) ? row.last_keep : '1;
      in_data_q.push_back(beat);
      in_keep_q.push_back(keep);
      in_last_q.push_back(b == int'(row.beats) - 1);
      for (int i = 0; i < S_WORDS; i++) begin
        if (keep[i]) begin
          words_q.push_back(beat[i]);
        end
      end
    end
    for (int j = 0; j <= int'(row.kw2); j++) begin
      out    = '0;
      out[0] = 8'd1;
      exp_data_q.push_back(out);
      exp_shift_q.push_back('0);
      exp_user_q.push_back(row.flags);
      exp_ones_q.push_back(1'b1);
      exp_last_q.push_back(1'b0);
    end
    w     = int'(row.words);
    s     = int'(row.sh_1) + 1;
    n_out = (words_q.size() + w - 1) / w;
    for (int j = 0; j < n_out; j++) begin
      out = '0;
      for (int i = 0; i < w; i++) begin
        if (words_q.size() != 0) begin
          out[i] = words_q.pop_front();
        end
      end
      exp_data_q.push_back(out);
      exp_shift_q.push_back(model_shift(int'(row.kh2), int'(row.sh_1), (j % s) == s - 1));
      exp_user_q.push_back(row.flags);
      exp_ones_q.push_back(1'b0);
      exp_last_q.push_back(j == n_out - 1);
    end
  endtask

  initial begin
    i_m_ready = 1'b0;
    forever begin
      @(negedge i_aclk);
      i_m_ready = (($random(seed) & 3) != 0);  // roughly one stall in four
    end
  end

  always @(posedge i_aclk) begin
    if (i_rst_n && o_m_valid && i_m_ready) begin
      if (exp_data_q.size() == 0) begin
        fail_run("an output beat arrived when none was expected");
      end else begin
        check_data("o_m_data", exp_data_q.pop_front(), o_m_data);
        check_shift("o_m_shift", exp_shift_q.pop_front(), o_m_shift);
        check_user("o_m_user", exp_user_q.pop_front(), o_m_user);
        check_flag("o_m_ones", exp_ones_q.pop_front(), o_m_ones);
        check_flag("o_m_last", exp_last_q.pop_front(), o_m_last);
      end
    end
  end

  always @(negedge i_aclk) begin
    if (u_pixels_dw_top.u_assertions.fired != 0) begin
      fail_run("a protocol assertion fired");
    end
  end

  initial begin
    #(CLK_PERIOD * watchdog_cycles());
    fail_run("timeout, the frames did not finish within the expected time");
  end

  initial begin
    i_rst_n   = 1'b0;
    i_s_valid = 1'b0;
    i_s_data  = '0;
    i_s_keep  = '0;
    i_s_last  = 1'b0;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      build_frame(FRAMES[f]);
    end
    repeat (RESET_CYCLES) @(negedge i_aclk);
    i_rst_n = 1'b1;
    while (in_data_q.size() != 0) begin
      @(negedge i_aclk);
      i_s_valid = 1'b1;
      i_s_data  = in_data_q.pop_front();
      i_s_keep  = in_keep_q.pop_front();
      i_s_last  = in_last_q.pop_front();
      @(posedge i_aclk);
      while (!o_s_ready) @(posedge i_aclk);  // beat held until the DUT takes it
    end
    @(negedge i_aclk);
    i_s_valid = 1'b0;
    i_s_last  = 1'b0;
    while (exp_data_q.size() != 0) @(negedge i_aclk);
    repeat (2) @(negedge i_aclk);
    if (!o_m_valid && o_s_ready) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      fail_run("the design did not return to idle after the last frame");
    end
  end

endmodule

// File: test/pixels_dw_assertions.sv
module pixels_dw_assertions import pixels_pkg::*; (
  input logic         i_aclk,
  input logic         i_rst_n,
  input logic         i_s_valid,
  input logic         i_s_last,
  input logic         i_m_ready,
  input logic         o_m_valid,
  input logic         o_m_last,
  input m_data_t      o_m_data,
  input logic         o_s_ready,
  input frame_state_e state
);

  int unsigned fired = 0;  // number of assertion failures so far
  logic        frame_closing;  // last input beat taken, last output beat not yet

  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      frame_closing <= 1'b0;
    end else if (o_m_valid && i_m_ready && o_m_last) begin
      frame_closing <= 1'b0;
    end else if (state != ST_SET && i_s_valid && o_s_ready && i_s_last) begin
      frame_closing <= 1'b1;
    end
  end

  m_valid_held: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    o_m_valid && !i_m_ready |=> o_m_valid && $stable(o_m_data))
  else begin
    fired++;
    $error("output beat changed or dropped while stalled");
  end

  s_ready_blocked: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    frame_closing |-> !o_s_ready)
  else begin
    fired++;
    $error("input accepted before the last output beat of the frame left");
  end

  block_in_frame_end: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    state == ST_BLOCK |-> frame_closing)
  else begin
    fired++;
    $error("next header held off without a pending last output beat");
  end

  // the reset is synchronous, so the outputs clear one edge later
  m_idle_after_reset: assert property (@(posedge i_aclk)
    !i_rst_n |=> !o_m_valid && !o_m_last)
  else begin
    fired++;
    $error("output stream active right after reset");
  end

endmodule

bind pixels_dw_top pixels_dw_assertions u_assertions (
  .i_aclk    (i_aclk),
  .i_rst_n   (i_rst_n),
  .i_s_valid (i_s_valid),
  .i_s_last  (i_s_last),
  .i_m_ready (i_m_ready),
  .o_m_valid (o_m_valid),
  .o_m_last  (o_m_last),
  .o_m_data  (o_m_data),
  .o_s_ready (o_s_ready),
  .state     (u_decode.state_q)
);

// File: logic/pixels_dw_top.sv
module pixels_dw_top import pixels_pkg::*; (
  input  logic    i_aclk,
  input  logic    i_rst_n,
  input  logic    i_s_valid,
  output logic    o_s_ready,
  input  s_data_t i_s_data,
  input  s_keep_t i_s_keep,
  input  logic    i_s_last,
  input  logic    i_m_ready,
  output logic    o_m_valid,
  output m_data_t o_m_data,
  output shift_t  o_m_shift,
  output logic    o_m_ones,
  output logic    o_m_last,
  output user_t   o_m_user
);

  frame_if frame_bus ();
  pack_if  pack_bus ();

  pixel_cfg_decode u_decode (
    .i_aclk    (i_aclk),
    .i_rst_n   (i_rst_n),
    .i_s_valid (i_s_valid),
    .i_s_ready (o_s_ready),
    .i_s_last  (i_s_last),
    .i_s_data  (i_s_data),
    .u_frame   (frame_bus.decode)
  );

  pixel_dw_pack u_pack (
    .i_aclk    (i_aclk),
    .i_rst_n   (i_rst_n),
    .i_s_valid (i_s_valid),
    .i_s_data  (i_s_data),
    .i_s_keep  (i_s_keep),
    .i_s_last  (i_s_last),
    .o_s_ready (o_s_ready),
    .u_frame   (frame_bus.pack),
    .u_pack    (pack_bus.source)
  );

  pixel_out_seq u_seq (
    .i_aclk    (i_aclk),
    .i_rst_n   (i_rst_n),
    .i_m_ready (i_m_ready),
    .o_m_valid (o_m_valid),
    .o_m_data  (o_m_data),
    .o_m_shift (o_m_shift),
    .o_m_ones  (o_m_ones),
    .o_m_last  (o_m_last),
    .o_m_user  (o_m_user),
    .u_frame   (frame_bus.seq),
    .u_pack    (pack_bus.sink)
  );

endmodule

// File: logic/pixel_out_seq.sv
module pixel_out_seq import pixels_pkg::*; (
  input  logic    i_aclk,
  input  logic    i_rst_n,
  input  logic    i_m_ready,
  output logic    o_m_valid,
  output m_data_t o_m_data,
  output shift_t  o_m_shift,
  output logic    o_m_ones,
  output logic    o_m_last,
  output user_t   o_m_user,
  frame_if.seq    u_frame,
  pack_if.sink    u_pack
);

  logic [BITS_ONES-1:0] ones_cnt;
  logic [BITS_SH-1:0]   stride_cnt;
  logic                 ones_last;
  logic                 stride_last;
  logic                 m_xfer;
  logic                 pack_ready;

  assign ones_last   = ones_cnt == calc_ones_beats(u_frame.cfg.kw2) - 1'b1;
  assign stride_last = stride_cnt == u_frame.cfg.sh_1;  // beat that closes a stride group
  assign m_xfer      = o_m_valid && i_m_ready;

  assign u_frame.ones_done = (u_frame.state == ST_ONES) && i_m_ready && ones_last;

  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      ones_cnt   <= '0;
      stride_cnt <= '0;
    end else begin
      unique case (u_frame.state)
        ST_SET: begin
          ones_cnt   <= '0;
          stride_cnt <= '0;
        end
        ST_ONES: begin
          if (i_m_ready) begin
            ones_cnt <= ones_last ? '0 : ones_cnt + 1'b1;
          end
        end
        default: begin
          if (m_xfer) begin
            stride_cnt <= stride_last ? '0 : stride_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  always_comb begin
    o_m_valid  = 1'b0;
    o_m_data   = '0;
    o_m_ones   = 1'b0;
    o_m_last   = 1'b0;
    pack_ready = 1'b0;
    o_m_shift  = stride_last ? calc_shift_last(u_frame.cfg.kh2, u_frame.cfg.sh_1)
                             : calc_shift_general(u_frame.cfg.kh2, u_frame.cfg.sh_1);
    unique case (u_frame.state)
      ST_ONES: begin
        o_m_valid   = 1'b1;
        o_m_data[0] = WORD_WIDTH'(1);  // bias and activation load pattern
        o_m_shift   = '0;
        o_m_ones    = 1'b1;
      end
      ST_PASS, ST_BLOCK: begin
        o_m_valid  = u_pack.valid;
        o_m_data   = u_pack.data;
        o_m_last   = u_pack.valid && u_pack.last;
        pack_ready = i_m_ready;
      end
      default: ;
    endcase
  end

  assign u_pack.ready = pack_ready;

  assign o_m_user[I_IS_NOT_MAX] = u_frame.cfg.is_not_max;
  assign o_m_user[I_IS_MAX]     = u_frame.cfg.is_max;
  assign o_m_user[I_IS_LRELU]   = u_frame.cfg.is_lrelu;

endmodule

// File: logic/pixel_dw_pack.sv
module pixel_dw_pack import pixels_pkg::*; (
  input  logic    i_aclk,
  input  logic    i_rst_n,
  input  logic    i_s_valid,
  input  s_data_t i_s_data,
  input  s_keep_t i_s_keep,
  input  logic    i_s_last,
  output logic    o_s_ready,
  frame_if.pack   u_frame,
  pack_if.source  u_pack
);

  logic [BUF_WORDS-1:0][WORD_WIDTH-1:0] buf_q;
  logic [BUF_WORDS-1:0][WORD_WIDTH-1:0] buf_next;
  logic [BITS_BUF-1:0]                  cnt_q;
  logic [BITS_BUF-1:0]                  cnt_next;
  logic [BITS_BUF-1:0]                  words_eff;
  logic                                 in_done;   // last input word of the image is in
  logic                                 take_in;
  logic                                 out_xfer;
  logic                                 last_xfer;
  logic                                 accepting;
  m_data_t                              m_data;

  // keep the width inside the range the output beat can carry
  always_comb begin
    words_eff = BITS_BUF'(u_frame.cfg.words);
    if (u_frame.cfg.words < UNITS) begin
      words_eff = BITS_BUF'(UNITS);
    end else if (u_frame.cfg.words > M_WORDS_MAX) begin
      words_eff = BITS_BUF'(M_WORDS_MAX);
    end
  end

  assign accepting = (u_frame.state == ST_ONES) || (u_frame.state == ST_PASS);
  assign o_s_ready = (u_frame.state == ST_SET) ||
                     (accepting && !in_done && cnt_q < words_eff);  // header always drained

  assign take_in   = i_s_valid && o_s_ready && (u_frame.state != ST_SET);
  assign out_xfer  = u_pack.valid && u_pack.ready;
  assign last_xfer = out_xfer && u_pack.last;

  always_comb begin
    buf_next = buf_q;
    cnt_next = cnt_q;
    if (out_xfer) begin
      buf_next = buf_q >> (int'(words_eff) * WORD_WIDTH);
      cnt_next = (cnt_q > words_eff) ? cnt_q - words_eff : '0;
    end
    if (take_in) begin
      for (int i = 0; i < S_WORDS; i++) begin
        if (i_s_keep[i] && cnt_next < BUF_WORDS) begin
          buf_next[cnt_next] = i_s_data[i];  // compact kept words, lowest index first
          cnt_next           = cnt_next + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_aclk) begin
    buf_q <= buf_next;
  end

  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      cnt_q   <= '0;
      in_done <= 1'b0;
    end else begin
      cnt_q <= cnt_next;
      if (last_xfer) begin
        in_done <= 1'b0;
      end else if (take_in && i_s_last) begin
        in_done <= 1'b1;
      end
    end
  end

  // words past the configured width or past the fill level go out as zero
  always_comb begin
    for (int i = 0; i < M_WORDS_MAX; i++) begin
      if (i < int'(words_eff) && i < int'(cnt_q)) begin
        m_data[i] = buf_q[i];
      end else begin
        m_data[i] = '0;
      end
    end
  end

  assign u_pack.data  = m_data;
  assign u_pack.valid = (cnt_q >= words_eff) || in_done;  // remainder flushes once input ends
  assign u_pack.last  = in_done && (cnt_q <= words_eff);

  assign u_frame.frame_done = last_xfer;

endmodule

// File: logic/pixel_cfg_decode.sv
module pixel_cfg_decode import pixels_pkg::*; (
  input  logic    i_aclk,
  input  logic    i_rst_n,
  input  logic    i_s_valid,
  input  logic    i_s_ready,
  input  logic    i_s_last,
  input  s_data_t i_s_data,
  frame_if.decode u_frame
);

  frame_state_e state_q;
  frame_state_e state_next;
  cfg_t         cfg_q;
  logic         s_beat;
  logic         s_last_beat;
  logic         last_early;            // image ended while ones beats were still going out
  logic         last_in;

  assign s_beat      = i_s_valid && i_s_ready;
  assign s_last_beat = s_beat && i_s_last;
  assign last_in     = s_last_beat || last_early;

  always_comb begin
    state_next = state_q;
    unique case (state_q)
      ST_SET: begin
        if (s_beat) begin
          state_next = ST_ONES;
        end
      end
      ST_ONES: begin
        if (u_frame.ones_done) begin
          state_next = ST_PASS;
        end
      end
      ST_PASS: begin
        if (last_in) begin
          state_next = u_frame.frame_done ? ST_SET : ST_BLOCK;
        end
      end
      ST_BLOCK: begin
        if (u_frame.frame_done) begin
          state_next = ST_SET;
        end
      end
      default: state_next = ST_SET;
    endcase
  end

  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      state_q    <= ST_SET;
      cfg_q      <= '0;
      last_early <= 1'b0;
    end else begin
      state_q <= state_next;
      if (state_q == ST_SET && s_beat) begin
        cfg_q <= cfg_t'(CFG_WIDTH'(i_s_data));  // header sits in the low bits of the beat
      end
      if (state_q == ST_SET) begin
        last_early <= 1'b0;
      end else if (state_q == ST_ONES && s_last_beat) begin
        last_early <= 1'b1;
      end
    end
  end

  assign u_frame.state = state_q;
  assign u_frame.cfg   = cfg_q;

endmodule

// File: logic/pixels_if.sv
// frame state and header config shared by the three blocks
interface frame_if import pixels_pkg::*; ();

  frame_state_e state;
  cfg_t         cfg;
  logic         ones_done;              // last ones beat taken downstream
  logic         frame_done;             // packed beat with last taken downstream

  modport decode (
    output state,
    output cfg,
    input  ones_done,
    input  frame_done
  );

  modport pack (
    input  state,
    input  cfg,
    output frame_done
  );

  modport seq (
    input  state,
    input  cfg,
    output ones_done
  );

endinterface

interface pack_if import pixels_pkg::*; ();

  m_data_t data;
  logic    valid;
  logic    ready;
  logic    last;

  modport source (
    output data,
    output valid,
    output last,
    input  ready
  );

  modport sink (
    input  data,
    input  valid,
    input  last,
    output ready
  );

endinterface

// File: logic/pixels_pkg.sv
package pixels_pkg;

  localparam int WORD_WIDTH  = 8;
  localparam int S_WORDS     = 4;
  localparam int M_WORDS_MAX = 8;
  localparam int UNITS       = 2;               // narrowest legal output beat
  localparam int KH_MAX      = 7;
  localparam int KW_MAX      = 7;
  localparam int SH_MAX      = 4;
  localparam int BUF_WORDS   = M_WORDS_MAX + S_WORDS;

  localparam int BITS_KH2   = $clog2(KH_MAX / 2 + 1);
  localparam int BITS_KW2   = $clog2(KW_MAX / 2 + 1);
  localparam int BITS_SH    = $clog2(SH_MAX);
  localparam int BITS_WORDS = $clog2(M_WORDS_MAX + 1);
  localparam int BITS_SHIFT = $clog2(KH_MAX);
  localparam int BITS_ONES  = $clog2(KW_MAX / 2 + 2);
  localparam int BITS_BUF   = $clog2(BUF_WORDS + 1);

  localparam int USER_WIDTH   = 3;
  localparam int I_IS_NOT_MAX = 0;
  localparam int I_IS_MAX     = 1;
  localparam int I_IS_LRELU   = 2;

  typedef logic [WORD_WIDTH-1:0]                  word_t;
  typedef logic [S_WORDS-1:0][WORD_WIDTH-1:0]     s_data_t;
  typedef logic [S_WORDS-1:0]                     s_keep_t;
  typedef logic [M_WORDS_MAX-1:0][WORD_WIDTH-1:0] m_data_t;
  typedef logic [BITS_SHIFT-1:0]                  shift_t;
  typedef logic [USER_WIDTH-1:0]                  user_t;

  // first field sits at the top of the header bits
  typedef struct packed {
    logic [BITS_WORDS-1:0] words;
    logic [BITS_SH-1:0]    sh_1;
    logic [BITS_KW2-1:0]   kw2;
    logic [BITS_KH2-1:0]   kh2;
    logic                  is_lrelu;
    logic                  is_max;
    logic                  is_not_max;
  } cfg_t;

  localparam int CFG_WIDTH = $bits(cfg_t);

  typedef enum logic [1:0] {
    ST_SET   = 2'd0,
    ST_ONES  = 2'd1,
    ST_PASS  = 2'd2,
    ST_BLOCK = 2'd3
  } frame_state_e;

  function automatic logic [BITS_ONES-1:0] calc_ones_beats(input logic [BITS_KW2-1:0] kw2);
    return BITS_ONES'(kw2) + 1'b1;
  endfunction

  function automatic shift_t calc_shift_general(input logic [BITS_KH2-1:0] kh2,
                                                input logic [BITS_SH-1:0]  sh_1);
    int k;
    int s;
    k = 2 * int'(kh2) + 1;
    s = int'(sh_1) + 1;
    return shift_t'((k + s - 1) / s - 1);  // ceil(k/s) - 1
  endfunction

  function automatic shift_t calc_shift_last(input logic [BITS_KH2-1:0] kh2,
                                             input logic [BITS_SH-1:0]  sh_1);
    int k;
    int s;
    k = 2 * int'(kh2) + 1;
    s = int'(sh_1) + 1;
    return shift_t'(k / s - 1);            // floor(k/s) - 1
  endfunction

endpackage
